//--- avs_pkg.sv
package avs_pkg;

    localparam int data_w        = 32;
    localparam int addr_w        = 10;
    localparam int tag_w         = 6;
    localparam int num_banks     = 4;
    localparam int rd_queue_size = 4;
    localparam int read_latency  = 2;
    localparam int byteen_w      = data_w / 8;

    typedef logic [data_w-1:0]   data_t;
    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [byteen_w-1:0] byteen_t;

    // the arbiter carries one bank's response with the data above the tag
    typedef struct packed {
        data_t data;
        tag_t  tag;
    } rsp_t;

endpackage

//--- avs_fifo.sv
`timescale 1ns/1ps

module avs_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     empty,
    output logic     full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         store [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth));
    assign data_out = store[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            store[wr_ptr] <= data_in;
        end
    end

    // pointers wrap explicitly so depth need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- avs_pending_count.sv
`timescale 1ns/1ps

module avs_pending_count #(
    parameter int size = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic incr,
    input  logic decr,
    output logic full
);

    localparam int cnt_w = $clog2(size + 1);

    logic [cnt_w-1:0] count;

    // a read issued and a response retired in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (incr && !decr) begin
            count <= count + 1'b1;
        end else if (decr && !incr) begin
            count <= count - 1'b1;
        end
    end

    assign full = (count == cnt_w'(size));

endmodule

//--- avs_rsp_arbiter.sv
`timescale 1ns/1ps

module avs_rsp_arbiter #(
    parameter int num_reqs = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [num_reqs-1:0]               valid_in,
    input  avs_pkg::rsp_t [num_reqs-1:0]      data_in,
    output logic [num_reqs-1:0]               ready_in,
    output logic                              valid_out,
    output avs_pkg::rsp_t                     data_out,
    input  logic                              ready_out
);

    localparam int sel_w = (num_reqs > 1) ? $clog2(num_reqs) : 1;

    logic [sel_w-1:0] rr_ptr;
    logic [sel_w-1:0] grant_idx;
    logic             grant_valid;
    logic             take;

    // the output register can load when it is empty or drains this cycle
    assign take = !valid_out || ready_out;

    // first valid input at or after the priority pointer wins
    always_comb begin : pick
        int idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int i = 0; i < num_reqs; i++) begin
            idx = (int'(rr_ptr) + i) % num_reqs;
            if (!grant_valid && valid_in[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = sel_w'(idx);
            end
        end
    end

    always_comb begin
        ready_in = '0;
        if (take && grant_valid) begin
            ready_in[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            rr_ptr    <= '0;
        end else if (take) begin
            valid_out <= grant_valid;
            if (grant_valid) begin
                rr_ptr <= (grant_idx == sel_w'(num_reqs - 1)) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && grant_valid) begin
            data_out <= data_in[grant_idx];
        end
    end

endmodule

//--- avs_bank_adapter.sv
`timescale 1ns/1ps

module avs_bank_adapter #(
    parameter int num_banks     = 4,
    parameter int rd_queue_size = 4
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 mem_req_valid,
    input  logic                 mem_req_rw,
    input  avs_pkg::byteen_t     mem_req_byteen,
    input  avs_pkg::addr_t       mem_req_addr,
    input  avs_pkg::data_t       mem_req_data,
    input  avs_pkg::tag_t        mem_req_tag,
    output logic                 mem_req_ready,

    output logic                 mem_rsp_valid,
    output avs_pkg::data_t       mem_rsp_data,
    output avs_pkg::tag_t        mem_rsp_tag,
    input  logic                 mem_rsp_ready,

    output logic                 avs_read [num_banks],
    output logic                 avs_write [num_banks],
    output avs_pkg::addr_t       avs_address [num_banks],
    output avs_pkg::byteen_t     avs_byteenable [num_banks],
    output avs_pkg::data_t       avs_writedata [num_banks],
    input  logic                 avs_waitrequest [num_banks],
    input  avs_pkg::data_t       avs_readdata [num_banks],
    input  logic                 avs_readdatavalid [num_banks]
);

    localparam int sel_w = (num_banks > 1) ? $clog2(num_banks) : 1;

    logic [sel_w-1:0]                 bank_sel;
    logic [num_banks-1:0]             pend_full;
    logic [num_banks-1:0]             bank_ready;
    logic [num_banks-1:0]             rd_push;
    logic [num_banks-1:0]             rsp_pop;
    logic [num_banks-1:0]             data_empty;
    logic [num_banks-1:0]             arb_ready;
    avs_pkg::tag_t                    tag_head [num_banks];
    avs_pkg::data_t                   data_head [num_banks];
    avs_pkg::rsp_t [num_banks-1:0]    arb_data;
    avs_pkg::rsp_t                    rsp_out;

    assign bank_sel = (num_banks > 1) ? mem_req_addr[sel_w-1:0] : '0;

    // writes are also held off while a bank is at its read limit
    assign mem_req_ready = bank_ready[bank_sel];

    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        logic hit;

        assign hit           = (bank_sel == sel_w'(i));
        assign bank_ready[i] = !pend_full[i] && !avs_waitrequest[i];
        assign rd_push[i]    = mem_req_valid && !mem_req_rw && hit && bank_ready[i];

        assign avs_read[i]       = mem_req_valid && !mem_req_rw && !pend_full[i] && hit;
        assign avs_write[i]      = mem_req_valid && mem_req_rw && !pend_full[i] && hit;
        assign avs_address[i]    = mem_req_addr;
        assign avs_byteenable[i] = mem_req_byteen;
        assign avs_writedata[i]  = mem_req_data;

        avs_pending_count #(
            .size (rd_queue_size)
        ) pending_inst (
            .clk  (clk),
            .rst  (rst),
            .incr (rd_push[i]),
            .decr (rsp_pop[i]),
            .full (pend_full[i])
        );

        avs_fifo #(
            .payload_t (avs_pkg::tag_t),
            .depth     (rd_queue_size)
        ) tag_fifo_inst (
            .clk      (clk),
            .rst      (rst),
            .push     (rd_push[i]),
            .pop      (rsp_pop[i]),
            .data_in  (mem_req_tag),
            .data_out (tag_head[i]),
            .empty    (),
            .full     ()
        );

        // the pending limit keeps this queue from ever overflowing
        avs_fifo #(
            .payload_t (avs_pkg::data_t),
            .depth     (rd_queue_size)
        ) data_fifo_inst (
            .clk      (clk),
            .rst      (rst),
            .push     (avs_readdatavalid[i]),
            .pop      (rsp_pop[i]),
            .data_in  (avs_readdata[i]),
            .data_out (data_head[i]),
            .empty    (data_empty[i]),
            .full     ()
        );

        assign arb_data[i].data = data_head[i];
        assign arb_data[i].tag  = tag_head[i];
        assign rsp_pop[i]       = !data_empty[i] && arb_ready[i];
    end

    avs_rsp_arbiter #(
        .num_reqs (num_banks)
    ) arbiter_inst (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (~data_empty),
        .data_in   (arb_data),
        .ready_in  (arb_ready),
        .valid_out (mem_rsp_valid),
        .data_out  (rsp_out),
        .ready_out (mem_rsp_ready)
    );

    assign mem_rsp_data = rsp_out.data;
    assign mem_rsp_tag  = rsp_out.tag;

endmodule

//--- avs_bank_ram.sv
`timescale 1ns/1ps

module avs_bank_ram #(
    parameter int num_banks    = 4,
    parameter int read_latency = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             read,
    input  logic             write,
    input  avs_pkg::addr_t   address,
    input  avs_pkg::byteen_t byteenable,
    input  avs_pkg::data_t   writedata,
    output logic             waitrequest,
    output avs_pkg::data_t   readdata,
    output logic             readdatavalid
);

    localparam int bank_bits = $clog2(num_banks);
    localparam int idx_w     = avs_pkg::addr_w - bank_bits;
    localparam int words     = (2 ** avs_pkg::addr_w) / num_banks;

    avs_pkg::data_t   mem [words];
    avs_pkg::data_t   rd_dat [read_latency];
    logic             rd_vld [read_latency];
    logic [idx_w-1:0] index;
    logic             wr_accept;
    logic             rd_accept;

    // the low address bits chose this bank, the rest pick the word
    assign index     = address[avs_pkg::addr_w-1 -: idx_w];
    assign wr_accept = write && !waitrequest;
    assign rd_accept = read && !waitrequest;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < words; w++) begin
                mem[w] <= '0;
            end
            waitrequest <= 1'b0;
        end else begin
            // one wait-state after every accepted write
            waitrequest <= wr_accept;
            if (wr_accept) begin
                for (int b = 0; b < avs_pkg::byteen_w; b++) begin
                    if (byteenable[b]) begin
                        mem[index][b*8 +: 8] <= writedata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < read_latency; s++) begin
                rd_vld[s] <= 1'b0;
            end
        end else begin
            rd_vld[0] <= rd_accept;
            for (int s = 1; s < read_latency; s++) begin
                rd_vld[s] <= rd_vld[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_dat[0] <= mem[index];
        for (int s = 1; s < read_latency; s++) begin
            rd_dat[s] <= rd_dat[s-1];
        end
    end

    assign readdatavalid = rd_vld[read_latency-1];
    assign readdata      = rd_dat[read_latency-1];

endmodule

//--- avs_mem_top.sv
`timescale 1ns/1ps

module avs_mem_top #(
    parameter int num_banks     = avs_pkg::num_banks,
    parameter int rd_queue_size = avs_pkg::rd_queue_size,
    parameter int read_latency  = avs_pkg::read_latency
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             mem_req_valid,
    input  logic             mem_req_rw,
    input  avs_pkg::byteen_t mem_req_byteen,
    input  avs_pkg::addr_t   mem_req_addr,
    input  avs_pkg::data_t   mem_req_data,
    input  avs_pkg::tag_t    mem_req_tag,
    output logic             mem_req_ready,

    output logic             mem_rsp_valid,
    output avs_pkg::data_t   mem_rsp_data,
    output avs_pkg::tag_t    mem_rsp_tag,
    input  logic             mem_rsp_ready
);

    logic             avs_read [num_banks];
    logic             avs_write [num_banks];
    avs_pkg::addr_t   avs_address [num_banks];
    avs_pkg::byteen_t avs_byteenable [num_banks];
    avs_pkg::data_t   avs_writedata [num_banks];
    logic             avs_waitrequest [num_banks];
    avs_pkg::data_t   avs_readdata [num_banks];
    logic             avs_readdatavalid [num_banks];

    avs_bank_adapter #(
        .num_banks     (num_banks),
        .rd_queue_size (rd_queue_size)
    ) adapter_inst (
        .clk               (clk),
        .rst               (rst),
        .mem_req_valid     (mem_req_valid),
        .mem_req_rw        (mem_req_rw),
        .mem_req_byteen    (mem_req_byteen),
        .mem_req_addr      (mem_req_addr),
        .mem_req_data      (mem_req_data),
        .mem_req_tag       (mem_req_tag),
        .mem_req_ready     (mem_req_ready),
        .mem_rsp_valid     (mem_rsp_valid),
        .mem_rsp_data      (mem_rsp_data),
        .mem_rsp_tag       (mem_rsp_tag),
        .mem_rsp_ready     (mem_rsp_ready),
        .avs_read          (avs_read),
        .avs_write         (avs_write),
        .avs_address       (avs_address),
        .avs_byteenable    (avs_byteenable),
        .avs_writedata     (avs_writedata),
        .avs_waitrequest   (avs_waitrequest),
        .avs_readdata      (avs_readdata),
        .avs_readdatavalid (avs_readdatavalid)
    );

    for (genvar i = 0; i < num_banks; i++) begin : g_ram
        avs_bank_ram #(
            .num_banks    (num_banks),
            .read_latency (read_latency)
        ) ram_inst (
            .clk           (clk),
            .rst           (rst),
            .read          (avs_read[i]),
            .write         (avs_write[i]),
            .address       (avs_address[i]),
            .byteenable    (avs_byteenable[i]),
            .writedata     (avs_writedata[i]),
            .waitrequest   (avs_waitrequest[i]),
            .readdata      (avs_readdata[i]),
            .readdatavalid (avs_readdatavalid[i])
        );
    end

endmodule

//--- avs_mem_assert.sv
`timescale 1ns/1ps

module avs_mem_assert (
    input logic           clk,
    input logic           rst,
    input logic           mem_req_valid,
    input logic           mem_req_rw,
    input logic           mem_req_ready,
    input logic           mem_rsp_valid,
    input avs_pkg::data_t mem_rsp_data,
    input avs_pkg::tag_t  mem_rsp_tag,
    input logic           mem_rsp_ready
);

    logic rd_taken;
    logic rsp_taken;
    int   outstanding;

    assign rd_taken  = mem_req_valid && mem_req_ready && !mem_req_rw;
    assign rsp_taken = mem_rsp_valid && mem_rsp_ready;

    // reads accepted minus responses delivered
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(rd_taken) - int'(rsp_taken);
        end
    end

    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid && !mem_rsp_ready |=>
            mem_rsp_valid && $stable(mem_rsp_data) && $stable(mem_rsp_tag))
        else $error("response changed while it was stalled");

    rsp_after_reset: assert property (@(posedge clk) rst |=> !mem_rsp_valid)
        else $error("response valid right after reset");

    rsp_has_read: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> outstanding > 0)
        else $error("response without an accepted read");

endmodule

bind avs_mem_top avs_mem_assert assert_inst (
    .clk           (clk),
    .rst           (rst),
    .mem_req_valid (mem_req_valid),
    .mem_req_rw    (mem_req_rw),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .mem_rsp_tag   (mem_rsp_tag),
    .mem_rsp_ready (mem_rsp_ready)
);

//--- avs_mem_tb.sv
`timescale 1ns/1ps

module avs_mem_tb;

    localparam int n_fill      = 16;
    localparam int n_part      = 16;
    localparam int n_part_rd   = 32;
    localparam int n_rand      = 150;
    localparam int n_stall     = 150;
    localparam int total_reqs  = 2 * n_fill + n_part + n_part_rd + n_rand + n_stall;
    localparam int cycle_limit = 20 * total_reqs + 200;
    localparam int num_tags    = 2 ** avs_pkg::tag_w;
    localparam int num_words   = 2 ** avs_pkg::addr_w;

    logic             clk;
    logic             rst;
    logic             mem_req_valid;
    logic             mem_req_rw;
    avs_pkg::byteen_t mem_req_byteen;
    avs_pkg::addr_t   mem_req_addr;
    avs_pkg::data_t   mem_req_data;
    avs_pkg::tag_t    mem_req_tag;
    logic             mem_req_ready;
    logic             mem_rsp_valid;
    avs_pkg::data_t   mem_rsp_data;
    avs_pkg::tag_t    mem_rsp_tag;
    logic             mem_rsp_ready;

    avs_pkg::data_t shadow [num_words];
    avs_pkg::data_t exp_data [num_tags];
    bit             tag_busy [num_tags];
    int             errors;
    int             checks;
    int             rd_count;
    int             rsp_count;
    int             refusals;
    int             tag_ptr;
    bit             rsp_random;
    bit             stall_phase;

    avs_mem_top avs_mem_top_inst (
        .clk            (clk),
        .rst            (rst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_tag    (mem_req_tag),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_tag    (mem_rsp_tag),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // the shadow memory merges a write's enabled bytes before it returns the word
    function automatic avs_pkg::data_t ref_read(input avs_pkg::addr_t addr, input logic wr,
                                                input avs_pkg::byteen_t be,
                                                input avs_pkg::data_t wdata);
        if (wr) begin
            for (int b = 0; b < avs_pkg::byteen_w; b++) begin
                if (be[b]) begin
                    shadow[addr][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
        return shadow[addr];
    endfunction

    task automatic check_data(input string name, input avs_pkg::data_t exp,
                              input avs_pkg::data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_tag(input avs_pkg::tag_t tag, output bit known);
        checks++;
        known = 1'b0;
        if ($isunknown(tag)) begin
            errors++;
            $display("response at %0t carries an unknown tag", $time);
        end else if (!tag_busy[tag]) begin
            errors++;
            $display("response tag %0d at %0t matches no outstanding read", tag, $time);
        end else begin
            known = 1'b1;
        end
    endtask

    task automatic alloc_tag(output avs_pkg::tag_t tag);
        int tries;
        tries = 0;
        while (tag_busy[tag_ptr]) begin
            tag_ptr = (tag_ptr + 1) % num_tags;
            tries++;
            if (tries == num_tags) begin
                @(negedge clk);
                tries = 0;
            end
        end
        tag = avs_pkg::tag_t'(tag_ptr);
        tag_ptr = (tag_ptr + 1) % num_tags;
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input logic rw, input avs_pkg::addr_t addr,
                            input avs_pkg::byteen_t be, input avs_pkg::data_t wdata);
        avs_pkg::tag_t  tag;
        avs_pkg::data_t expv;
        logic           accepted;
        int             attempts;
        tag = '0;
        if (!rw) begin
            alloc_tag(tag);
        end
        mem_req_valid  = 1'b1;
        mem_req_rw     = rw;
        mem_req_addr   = addr;
        mem_req_byteen = be;
        mem_req_data   = wdata;
        mem_req_tag    = tag;
        accepted       = 1'b0;
        attempts       = 0;
        while (!accepted) begin
            #1;
            accepted = mem_req_ready;
            // a refusal after the one-cycle write wait-state means the read limit is full
            if (!accepted && !rw && stall_phase && attempts > 0) begin
                refusals++;
            end
            attempts++;
            @(posedge clk);
            if (accepted) begin
                expv = ref_read(addr, rw, be, wdata);
                if (!rw) begin
                    exp_data[tag] = expv;
                    tag_busy[tag] = 1'b1;
                    rd_count++;
                end
            end
            @(negedge clk);
        end
        mem_req_valid = 1'b0;
    endtask

    // response side drives ready, then compares every transfer it sees
    initial begin : rsp_side
        int stall_left;
        bit known;
        stall_left    = 0;
        mem_rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (!rsp_random || rst) begin
                mem_rsp_ready = 1'b1;
            end else if (stall_left > 0) begin
                mem_rsp_ready = 1'b0;
                stall_left--;
            end else if ($urandom_range(15) == 0) begin
                stall_left    = 20 + $urandom_range(20);
                mem_rsp_ready = 1'b0;
            end else begin
                mem_rsp_ready = 1'($urandom_range(1));
            end
            #1;
            if (!rst && mem_rsp_valid && mem_rsp_ready) begin
                check_tag(mem_rsp_tag, known);
                if (known) begin
                    check_data("mem_rsp_data", exp_data[mem_rsp_tag], mem_rsp_data);
                    tag_busy[mem_rsp_tag] = 1'b0;
                end
                rsp_count++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, responses are missing: %0d of %0d received",
                 cycles, rsp_count, rd_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic rw;
        int   busy_left;
        void'($urandom(32'h7a06502a));
        errors         = 0;
        checks         = 0;
        rd_count       = 0;
        rsp_count      = 0;
        refusals       = 0;
        tag_ptr        = 0;
        rsp_random     = 1'b0;
        stall_phase    = 1'b0;
        rst            = 1'b1;
        mem_req_valid  = 1'b0;
        mem_req_rw     = 1'b0;
        mem_req_byteen = '0;
        mem_req_addr   = '0;
        mem_req_data   = '0;
        mem_req_tag    = '0;
        for (int w = 0; w < num_words; w++) begin
            shadow[w] = '0;
        end
        for (int t = 0; t < num_tags; t++) begin
            tag_busy[t] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_flag("mem_rsp_valid", 1'b0, mem_rsp_valid);
        check_flag("mem_req_ready", 1'b1, mem_req_ready);
        @(negedge clk);

        // full words into every bank, then read them back
        for (int i = 0; i < n_fill; i++) begin
            send_req(1'b1, avs_pkg::addr_t'(i), '1, $urandom());
        end
        for (int i = 0; i < n_fill; i++) begin
            send_req(1'b0, avs_pkg::addr_t'(i), '0, '0);
        end

        for (int i = 0; i < n_part; i++) begin
            send_req(1'b1, avs_pkg::addr_t'($urandom_range(n_part_rd - 1)),
                     avs_pkg::byteen_t'($urandom_range(14, 1)), $urandom());
        end
        for (int i = 0; i < n_part_rd; i++) begin
            send_req(1'b0, avs_pkg::addr_t'(i), '0, '0);
        end

        for (int i = 0; i < n_rand; i++) begin
            rw = ($urandom_range(3) == 0);
            send_req(rw, avs_pkg::addr_t'($urandom_range(63)), avs_pkg::byteen_t'($urandom()),
                     $urandom());
        end

        // random back-pressure with long stalls fills the read limit
        rsp_random  = 1'b1;
        stall_phase = 1'b1;
        for (int i = 0; i < n_stall; i++) begin
            rw = ($urandom_range(7) == 0);
            send_req(rw, avs_pkg::addr_t'($urandom_range(63)), avs_pkg::byteen_t'($urandom()),
                     $urandom());
        end
        stall_phase = 1'b0;
        rsp_random  = 1'b0;

        while (rsp_count != rd_count) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        if (rsp_count != rd_count) begin
            errors++;
            $display("%0d responses came back for %0d accepted reads", rsp_count, rd_count);
        end
        busy_left = 0;
        for (int t = 0; t < num_tags; t++) begin
            busy_left += int'(tag_busy[t]);
        end
        if (busy_left != 0) begin
            errors++;
            $display("%0d reads never received a response", busy_left);
        end
        if (refusals == 0) begin
            errors++;
            $display("mem_req_ready never held off a read at the pending limit");
        end

        $display("checks %0d, errors %0d, reads %0d, responses %0d, stalled reads %0d",
                 checks, errors, rd_count, rsp_count, refusals);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sim.f
avs_pkg.sv
avs_fifo.sv
avs_pending_count.sv
avs_rsp_arbiter.sv
avs_bank_adapter.sv
avs_bank_ram.sv
avs_mem_top.sv
avs_mem_assert.sv
avs_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the memory testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module avs_mem_tb -o avs_mem_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/avs_mem_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$log"; then
    exit 0
fi
echo "simulation reported failures, see $log"
exit 1
